// File: sim.f
+incdir+include
rtl/periph_pkg.sv
rtl/sync_fifo.sv
rtl/code_queue.sv
rtl/uart_core.sv
rtl/io_pin_regs.sv
rtl/apb_decoder.sv
rtl/periph_top.sv
dv/tb_periph.sv

// File: Makefile
# Verilator build for the peripheral register block testbench

VERILATOR ?= verilator
TOP       ?= tb_periph
SEED      ?= 45
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary -j 0 -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/periph_input.txt
# op test f0 f1 f2, hex fields, unused zero; P pins as {csn,sclk,mosi}
# W addr wdata slverr | R addr rdata slverr (USB, pins use driven inputs) | K S T byte
N 1 0 0 0
P 1 0 4 4
W 1 1000 a5c3 0
P 1 c3 4 4
E 1 0 0 0
N 2 0 0 0
W 2 2000 5a 0
R 2 2004 1 0
W 2 2000 33 0
T 2 5a 0 0
R 2 2004 0 0
E 2 0 0 0
N 3 0 0 0
S 3 a7 0 0
S 3 3c 0 0
S 3 e1 0 0
R 3 2004 2 0
W 3 2004 0 0
R 3 2000 a7 0
W 3 2004 0 0
R 3 2000 3c 0
W 3 2004 0 0
R 3 2000 e1 0
R 3 2004 0 0
E 3 0 0 0
N 4 0 0 0
K 4 11 0 0
K 4 22 0 0
K 4 33 0 0
K 4 44 0 0
K 4 55 0 0
K 4 66 0 0
K 4 77 0 0
K 4 88 0 0
K 4 99 0 0
R 4 5000 1 0
W 4 5000 0 0
R 4 5004 11 0
W 4 5000 0 0
R 4 5004 22 0
W 4 5000 0 0
R 4 5004 33 0
W 4 5000 0 0
R 4 5004 44 0
W 4 5000 0 0
R 4 5004 55 0
W 4 5000 0 0
R 4 5004 66 0
W 4 5000 0 0
R 4 5004 77 0
W 4 5000 0 0
R 4 5004 88 0
R 4 5000 0 0
W 4 5000 0 0
R 4 5004 88 0
E 4 0 0 0
N 5 0 0 0
R 5 4000 0 0
R 5 4004 0 0
R 5 4008 0 0
W 5 6000 5 0
W 5 7000 2 0
P 5 c3 7 0
R 5 6000 0 0
R 5 7000 0 0
W 5 6000 6 0
W 5 7000 1 0
P 5 c3 2 5
E 5 0 0 0
N 6 0 0 0
W 6 3000 ff 1
R 6 3000 0 1
W 6 2008 ff 1
R 6 2008 0 1
W 6 1004 ff 1
P 6 c3 2 5
E 6 0 0 0

// File: include/tb_defs.svh
// Peripheral testbench definitions
// Run constants, stimulus record layout and the value check
`ifndef TB_DEFS_SVH
`define TB_DEFS_SVH

localparam int    TB_CLK_PERIOD     = 4;
localparam int    TB_RESET_CYCLES   = 8;
localparam int    TB_SEED           = 45;
localparam int    TB_WDOG_BITS_LINE = 40;
localparam string TB_INPUT_FILE     = "dv/periph_input.txt";

// One line is an opcode, a test number and three hex fields
// W  addr, wdata, expected slverr
// R  addr, expected rdata, expected slverr
// K  code;  S  byte to send on rx;  T  expected tx byte
// P  display, sd pins, flash pins as {csn, sclk, mosi}
// N  start of test, E  end of test, unused fields zero
typedef struct {
    byte         op;
    int          test;
    logic [31:0] f0;
    logic [31:0] f1;
    logic [31:0] f2;
} tb_rec_t;

task automatic tb_check(input string what, input logic [31:0] got,
                        input logic [31:0] exp, inout int unsigned errs);
    if (got !== exp) begin
        $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
        errs++;
    end
endtask

`endif

// File: dv/tb_periph.sv
// Peripheral block testbench
// APB master, serial driver and monitor, file-driven test sequence
`timescale 1ns/10ps

module tb_periph;
    import periph_pkg::*;

    `include "tb_defs.svh"

    localparam int APB_WAIT_LIMIT = 16;
    localparam int TX_WAIT_CYCLES = 20 * UART_CLKS_PER_BIT;

    logic              clk;
    logic              reset;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    word_t             pwdata;
    word_t             prdata;
    logic              pready;
    logic              pslverr;
    logic              rx;
    logic              tx;
    byte_t             kbd_code;
    logic              kbd_strobe;
    logic [63:0]       usb_report;
    logic              usb_valid;
    byte_t             display;
    logic              sd_csn;
    logic              sd_sclk;
    logic              sd_mosi;
    logic              sd_miso;
    logic              flash_csn;
    logic              flash_sclk;
    logic              flash_mosi;
    logic              flash_miso;

    int          seed = TB_SEED;
    int unsigned errors = 0;
    int unsigned test_start_errs = 0;
    int          cur_test = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    longint      wdog_ns;
    logic        loaded;
    tb_rec_t     recs[$];
    byte_t       tx_q[$];
    logic        tx_in_frame;

    periph_top u_dut (
        .clk                (clk),
        .reset_i            (reset),
        .psel_i             (psel),
        .penable_i          (penable),
        .pwrite_i           (pwrite),
        .paddr_i            (paddr),
        .pwdata_i           (pwdata),
        .prdata_o           (prdata),
        .pready_o           (pready),
        .pslverr_o          (pslverr),
        .rx_i               (rx),
        .tx_o               (tx),
        .kbd_code_i         (kbd_code),
        .kbd_strobe_i       (kbd_strobe),
        .usb_report_i       (usb_report),
        .usb_report_valid_i (usb_valid),
        .display_o          (display),
        .sd_csn_o           (sd_csn),
        .sd_sclk_o          (sd_sclk),
        .sd_mosi_o          (sd_mosi),
        .sd_miso_i          (sd_miso),
        .flash_csn_o        (flash_csn),
        .flash_sclk_o       (flash_sclk),
        .flash_mosi_o       (flash_mosi),
        .flash_miso_i       (flash_miso)
    );

    initial begin
        clk = 1'b0;
        forever #(TB_CLK_PERIOD / 2) clk = ~clk;
    end

    // Idle bus, serial line high, reset held
    initial begin
        reset      <= 1'b1;
        psel       <= 1'b0;
        penable    <= 1'b0;
        pwrite     <= 1'b0;
        paddr      <= '0;
        pwdata     <= '0;
        rx         <= 1'b1;
        kbd_code   <= '0;
        kbd_strobe <= 1'b0;
        usb_report <= '0;
        usb_valid  <= 1'b0;
        sd_miso    <= 1'b0;
        flash_miso <= 1'b0;
    end

    // Decodes every frame on tx, sampling each bit near its middle
    initial begin
        byte_t b;
        int    i;
        tx_in_frame = 1'b0;
        forever begin
            @(negedge clk);
            if (!reset && tx === 1'b0) begin
                tx_in_frame = 1'b1;
                repeat (UART_CLKS_PER_BIT / 2) @(negedge clk);
                tb_check("tx start bit", 32'(tx), 32'd0, errors);
                for (i = 0; i < 8; i++) begin
                    repeat (UART_CLKS_PER_BIT) @(negedge clk);
                    b[i] = tx;
                end
                repeat (UART_CLKS_PER_BIT) @(negedge clk);
                tb_check("tx stop bit", 32'(tx), 32'd1, errors);
                tx_q.push_back(b);
                tx_in_frame = 1'b0;
            end
        end
    end

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        tb_rec_t     rec;
        fd = $fopen(TB_INPUT_FILE, "r");
        loaded = (fd != 0);
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 2 && line.getc(0) != "#") begin
                    n = $sscanf(line, " %c %d %h %h %h", rec.op, rec.test,
                                rec.f0, rec.f1, rec.f2);
                    if (n == 5) begin
                        recs.push_back(rec);
                    end else begin
                        $display("Stimulus line not understood: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apb_transfer(input logic write, input logic [ADDR_W-1:0] addr,
                                input word_t wdata, output word_t rdata,
                                output logic slverr);
        int   waited;
        logic done;
        rdata  = '0;
        slverr = 1'b0;
        done   = 1'b0;
        waited = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        while (!done && waited < APB_WAIT_LIMIT) begin
            @(negedge clk);
            if (pready) begin
                done   = 1'b1;
                rdata  = prdata;
                slverr = pslverr;
            end
            @(posedge clk);
            waited++;
        end
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        if (!done) begin
            $display("APB transfer to address %h never saw pready", addr);
            errors++;
        end
    endtask

    task automatic push_key(input byte_t code);
        @(posedge clk);
        kbd_code   <= code;
        kbd_strobe <= 1'b1;
        @(posedge clk);
        kbd_strobe <= 1'b0;
    endtask

    // 8-N-1 frame on rx with the LSB first
    task automatic send_serial(input byte_t b);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, b, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= frame[i];
            repeat (UART_CLKS_PER_BIT - 1) @(posedge clk);
        end
        @(posedge clk);
    endtask

    // Expected byte and then over a frame of quiet line
    task automatic expect_tx(input byte_t exp);
        int waited;
        waited = 0;
        while (tx_q.size() == 0 && waited < TX_WAIT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (tx_q.size() == 0) begin
            $display("No frame appeared on tx_o in test %0d", cur_test);
            errors++;
        end else begin
            tb_check("tx byte", 32'(tx_q.pop_front()), 32'(exp), errors);
            repeat (12 * UART_CLKS_PER_BIT) @(negedge clk);
            tb_check("extra tx frames", 32'(tx_q.size()) + 32'(tx_in_frame), 32'd0, errors);
        end
    endtask

    task automatic check_pins(input word_t disp_exp, input word_t sd_exp,
                              input word_t flash_exp);
        @(negedge clk);
        tb_check("display_o", 32'(display), disp_exp, errors);
        tb_check("sd pins", 32'({sd_csn, sd_sclk, sd_mosi}), sd_exp, errors);
        tb_check("flash pins", 32'({flash_csn, flash_sclk, flash_mosi}), flash_exp, errors);
    endtask

    task automatic randomize_inputs();
        word_t hi;
        word_t lo;
        word_t bits;
        hi   = $random(seed);
        lo   = $random(seed);
        bits = $random(seed);
        @(posedge clk);
        usb_report <= {hi, lo};
        usb_valid  <= bits[0];
        sd_miso    <= bits[1];
        flash_miso <= bits[2];
    endtask

    // Registers backed by the random inputs read what was driven
    function automatic word_t expected_read(input logic [ADDR_W-1:0] addr,
                                            input word_t file_val);
        logic [3:0]  pg;
        logic [11:0] ofs;
        pg  = addr[15:12];
        ofs = addr[11:0];
        if (pg == PAGE_USB && ofs == OFS_0) return 32'(usb_valid);
        if (pg == PAGE_USB && ofs == OFS_4) return usb_report[63:32];
        if (pg == PAGE_USB && ofs == OFS_8) return usb_report[31:0];
        if (pg == PAGE_SD && ofs == OFS_0) return 32'(sd_miso);
        if (pg == PAGE_FLASH && ofs == OFS_0) return 32'(flash_miso);
        return file_val;
    endfunction

    task automatic run_record(input tb_rec_t rec);
        word_t rdata;
        logic  slverr;
        case (rec.op)
            "N": begin
                cur_test        = rec.test;
                test_start_errs = errors;
                randomize_inputs();
            end
            "W": begin
                apb_transfer(1'b1, rec.f0[ADDR_W-1:0], rec.f1, rdata, slverr);
                tb_check($sformatf("write %h slverr", rec.f0[15:0]), 32'(slverr),
                         rec.f2, errors);
            end
            "R": begin
                apb_transfer(1'b0, rec.f0[ADDR_W-1:0], '0, rdata, slverr);
                tb_check($sformatf("read %h data", rec.f0[15:0]), rdata,
                         expected_read(rec.f0[ADDR_W-1:0], rec.f1), errors);
                tb_check($sformatf("read %h slverr", rec.f0[15:0]), 32'(slverr),
                         rec.f2, errors);
            end
            "K": push_key(rec.f0[7:0]);
            "S": send_serial(rec.f0[7:0]);
            "T": expect_tx(rec.f0[7:0]);
            "P": check_pins(rec.f0, rec.f1, rec.f2);
            "E": begin
                tests_run++;
                if (errors == test_start_errs) begin
                    $display("Test %0d passed", cur_test);
                end else begin
                    tests_failed++;
                    $display("Test %0d failed with %0d errors", cur_test,
                             errors - test_start_errs);
                end
            end
            default: begin
                $display("Unknown opcode %c in stimulus", rec.op);
                errors++;
            end
        endcase
    endtask

    initial begin
        load_stimulus();
        if (!loaded) begin
            $display("Cannot open stimulus file %s", TB_INPUT_FILE);
            $display("Simulation failed");
            $finish;
        end else begin
            wdog_ns = longint'(recs.size()) * TB_WDOG_BITS_LINE * UART_CLKS_PER_BIT
                      * TB_CLK_PERIOD;
            fork
                begin
                    #(wdog_ns);
                    $display("Watchdog expired after %0d ns, run stopped", wdog_ns);
                    $display("Simulation failed");
                    $finish;
                end
            join_none
            repeat (TB_RESET_CYCLES) @(posedge clk);
            reset <= 1'b0;
            foreach (recs[k]) begin
                run_record(recs[k]);
            end
            $display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
                     tests_run, tests_run - tests_failed, tests_failed, errors);
            if (errors == 0 && tests_run > 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

// File: rtl/periph_top.sv
// Peripheral block top level
// APB register decode, UART with receive queue, keyboard queue and pin ports
`timescale 1ns/10ps

module periph_top (
    input  logic                          clk,
    input  logic                          reset_i,
    // APB slave
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [periph_pkg::ADDR_W-1:0] paddr_i,
    input  periph_pkg::word_t             pwdata_i,
    output periph_pkg::word_t             prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o,
    // Serial port
    input  logic                          rx_i,
    output logic                          tx_o,
    // Keyboard and USB
    input  periph_pkg::byte_t             kbd_code_i,
    input  logic                          kbd_strobe_i,
    input  logic [63:0]                   usb_report_i,
    input  logic                          usb_report_valid_i,
    // Pins
    output periph_pkg::byte_t             display_o,
    output logic                          sd_csn_o,
    output logic                          sd_sclk_o,
    output logic                          sd_mosi_o,
    input  logic                          sd_miso_i,
    output logic                          flash_csn_o,
    output logic                          flash_sclk_o,
    output logic                          flash_mosi_o,
    input  logic                          flash_miso_i
);
    import periph_pkg::*;

    logic  disp_we;
    logic  sd_we;
    logic  flash_we;
    logic  uart_tx_we;
    logic  uart_pop;
    logic  kbd_pop;
    logic  uart_busy;
    logic  uart_ne;
    logic  kbd_ne;
    logic  uart_rx_valid;
    byte_t uart_rx_data;
    byte_t uart_code;
    byte_t kbd_code;

    apb_decoder u_decoder (
        .clk                (clk),
        .reset_i            (reset_i),
        .psel_i             (psel_i),
        .penable_i          (penable_i),
        .pwrite_i           (pwrite_i),
        .paddr_i            (paddr_i),
        .prdata_o           (prdata_o),
        .pready_o           (pready_o),
        .pslverr_o          (pslverr_o),
        .uart_busy_i        (uart_busy),
        .uart_ne_i          (uart_ne),
        .uart_code_i        (uart_code),
        .kbd_ne_i           (kbd_ne),
        .kbd_code_i         (kbd_code),
        .usb_report_i       (usb_report_i),
        .usb_report_valid_i (usb_report_valid_i),
        .sd_miso_i          (sd_miso_i),
        .flash_miso_i       (flash_miso_i),
        .disp_we_o          (disp_we),
        .sd_we_o            (sd_we),
        .flash_we_o         (flash_we),
        .uart_tx_we_o       (uart_tx_we),
        .uart_pop_o         (uart_pop),
        .kbd_pop_o          (kbd_pop)
    );

    uart_core u_uart (
        .clk        (clk),
        .reset_i    (reset_i),
        .rx_i       (rx_i),
        .tx_o       (tx_o),
        .tx_we_i    (uart_tx_we),
        .tx_data_i  (pwdata_i[7:0]),
        .busy_o     (uart_busy),
        .rx_valid_o (uart_rx_valid),
        .rx_data_o  (uart_rx_data)
    );

    // Received bytes wait here until software pops them
    code_queue #(.AW(UART_Q_AW)) u_uart_rxq (
        .clk         (clk),
        .reset_i     (reset_i),
        .push_i      (uart_rx_valid),
        .push_data_i (uart_rx_data),
        .pop_i       (uart_pop),
        .not_empty_o (uart_ne),
        .code_o      (uart_code)
    );

    code_queue #(.AW(KBD_Q_AW)) u_kbd_q (
        .clk         (clk),
        .reset_i     (reset_i),
        .push_i      (kbd_strobe_i),
        .push_data_i (kbd_code_i),
        .pop_i       (kbd_pop),
        .not_empty_o (kbd_ne),
        .code_o      (kbd_code)
    );

    io_pin_regs u_pins (
        .clk          (clk),
        .reset_i      (reset_i),
        .wdata_i      (pwdata_i[7:0]),
        .disp_we_i    (disp_we),
        .sd_we_i      (sd_we),
        .flash_we_i   (flash_we),
        .display_o    (display_o),
        .sd_csn_o     (sd_csn_o),
        .sd_sclk_o    (sd_sclk_o),
        .sd_mosi_o    (sd_mosi_o),
        .flash_csn_o  (flash_csn_o),
        .flash_sclk_o (flash_sclk_o),
        .flash_mosi_o (flash_mosi_o)
    );

endmodule

// File: rtl/apb_decoder.sv
// APB slave for the peripheral page map
// Zero wait states, write strobes, read mux and slave error on unmapped addresses
`timescale 1ns/10ps

module apb_decoder (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [periph_pkg::ADDR_W-1:0] paddr_i,
    output periph_pkg::word_t             prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o,
    input  logic                          uart_busy_i,
    input  logic                          uart_ne_i,
    input  periph_pkg::byte_t             uart_code_i,
    input  logic                          kbd_ne_i,
    input  periph_pkg::byte_t             kbd_code_i,
    input  logic [63:0]                   usb_report_i,
    input  logic                          usb_report_valid_i,
    input  logic                          sd_miso_i,
    input  logic                          flash_miso_i,
    output logic                          disp_we_o,
    output logic                          sd_we_o,
    output logic                          flash_we_o,
    output logic                          uart_tx_we_o,
    output logic                          uart_pop_o,
    output logic                          kbd_pop_o
);
    import periph_pkg::*;

    logic [3:0]  page;
    logic [11:0] ofs;
    logic        mapped;
    logic        wr_acc;
    logic        err_q;

    assign page = paddr_i[ADDR_W-1:ADDR_W-4];
    assign ofs  = paddr_i[11:0];

    // Register list per page
    always_comb begin
        case (page)
            PAGE_DISPLAY, PAGE_SD, PAGE_FLASH: mapped = (ofs == OFS_0);
            PAGE_UART, PAGE_KBD:               mapped = (ofs == OFS_0) || (ofs == OFS_4);
            PAGE_USB: mapped = (ofs == OFS_0) || (ofs == OFS_4) || (ofs == OFS_8);
            default:                           mapped = 1'b0;
        endcase
    end

    // Strobes only in the access cycle of a write
    assign wr_acc       = psel_i && penable_i && pwrite_i;
    assign disp_we_o    = wr_acc && (page == PAGE_DISPLAY) && (ofs == OFS_0);
    assign sd_we_o      = wr_acc && (page == PAGE_SD) && (ofs == OFS_0);
    assign flash_we_o   = wr_acc && (page == PAGE_FLASH) && (ofs == OFS_0);
    assign uart_tx_we_o = wr_acc && (page == PAGE_UART) && (ofs == OFS_0);
    assign uart_pop_o   = wr_acc && (page == PAGE_UART) && (ofs == OFS_4);
    assign kbd_pop_o    = wr_acc && (page == PAGE_KBD) && (ofs == OFS_0);

    // Address is stable from setup, so the error flag is taken there
    always_ff @(posedge clk) begin
        if (reset_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= psel_i && !penable_i && !mapped;
        end
    end

    assign pslverr_o = err_q && psel_i && penable_i;
    assign pready_o  = 1'b1;

    // Read mux, kept combinational so freshly popped codes are seen
    always_comb begin
        prdata_o = '0;
        if (psel_i && !pwrite_i) begin
            case (page)
                PAGE_UART: begin
                    if (ofs == OFS_0) begin
                        prdata_o = word_t'(uart_code_i);
                    end else if (ofs == OFS_4) begin
                        prdata_o = word_t'({uart_ne_i, uart_busy_i});
                    end
                end
                PAGE_USB: begin
                    if (ofs == OFS_0) begin
                        prdata_o = word_t'(usb_report_valid_i);
                    end else if (ofs == OFS_4) begin
                        prdata_o = usb_report_i[63:32];
                    end else if (ofs == OFS_8) begin
                        prdata_o = usb_report_i[31:0];
                    end
                end
                PAGE_KBD: begin
                    if (ofs == OFS_0) begin
                        prdata_o = word_t'(kbd_ne_i);
                    end else if (ofs == OFS_4) begin
                        prdata_o = word_t'(kbd_code_i);
                    end
                end
                PAGE_SD:    if (ofs == OFS_0) prdata_o = word_t'(sd_miso_i);
                PAGE_FLASH: if (ofs == OFS_0) prdata_o = word_t'(flash_miso_i);
                default:    prdata_o = '0;
            endcase
        end
    end

endmodule

// File: rtl/io_pin_regs.sv
// Display register and SD card / flash bit-banged SPI pins
`timescale 1ns/10ps

module io_pin_regs (
    input  logic              clk,
    input  logic              reset_i,
    input  periph_pkg::byte_t wdata_i,
    input  logic              disp_we_i,
    input  logic              sd_we_i,
    input  logic              flash_we_i,
    output periph_pkg::byte_t display_o,
    output logic              sd_csn_o,
    output logic              sd_sclk_o,
    output logic              sd_mosi_o,
    output logic              flash_csn_o,
    output logic              flash_sclk_o,
    output logic              flash_mosi_o
);
    import periph_pkg::*;

    // Write bits 0 mosi, 1 cs, 2 sclk, packed as {sclk, csn, mosi}
    function automatic logic [2:0] spi_pins(input byte_t w);
        return {w[2], ~w[1], w[0]};
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            display_o                                <= '0;
            {sd_sclk_o, sd_csn_o, sd_mosi_o}          <= 3'b010;
            {flash_sclk_o, flash_csn_o, flash_mosi_o} <= 3'b010;
        end else begin
            if (disp_we_i) begin
                display_o <= wdata_i;
            end
            if (sd_we_i) begin
                {sd_sclk_o, sd_csn_o, sd_mosi_o} <= spi_pins(wdata_i);
            end
            if (flash_we_i) begin
                {flash_sclk_o, flash_csn_o, flash_mosi_o} <= spi_pins(wdata_i);
            end
        end
    end

endmodule

// File: rtl/uart_core.sv
// 8-N-1 serial transmitter and receiver
// Fixed clocks-per-bit divider, receiver samples at mid-bit
`timescale 1ns/10ps

module uart_core (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              rx_i,
    output logic              tx_o,
    input  logic              tx_we_i,
    input  periph_pkg::byte_t tx_data_i,
    output logic              busy_o,
    output logic              rx_valid_o,
    output periph_pkg::byte_t rx_data_o
);
    import periph_pkg::*;

    logic [UART_CNT_W-1:0] tx_baud;
    logic [3:0]            tx_bit;
    logic [8:0]            tx_shift;
    logic                  tx_tick;

    logic                  rx_s1;
    logic                  rx_s2;
    logic                  rx_busy;
    logic [UART_CNT_W-1:0] rx_baud;
    logic [3:0]            rx_bit;
    logic                  rx_tick;
    byte_t                 rx_shift;

    assign tx_tick = (tx_baud == UART_CNT_W'(UART_CLKS_PER_BIT - 1));
    assign rx_tick = (rx_baud == UART_CNT_W'(UART_CLKS_PER_BIT - 1));

    // Transmit, start bit driven straight from the write
    always_ff @(posedge clk) begin
        if (reset_i) begin
            tx_o    <= 1'b1;
            busy_o  <= 1'b0;
            tx_baud <= '0;
            tx_bit  <= '0;
        end else if (!busy_o) begin
            if (tx_we_i) begin
                tx_o    <= 1'b0;
                busy_o  <= 1'b1;
                tx_baud <= '0;
                tx_bit  <= '0;
            end
        end else if (tx_tick) begin
            tx_baud <= '0;
            if (tx_bit == 4'd9) begin
                // Stop bit has had its full time
                busy_o <= 1'b0;
            end else begin
                tx_o   <= tx_shift[0];
                tx_bit <= tx_bit + 4'd1;
            end
        end else begin
            tx_baud <= tx_baud + 1'b1;
        end
    end

    // Data then stop bit, ones shifted in behind
    always_ff @(posedge clk) begin
        if (!busy_o && tx_we_i) begin
            tx_shift <= {1'b1, tx_data_i};
        end else if (busy_o && tx_tick) begin
            tx_shift <= {1'b1, tx_shift[8:1]};
        end
    end

    // Receive control
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rx_s1      <= 1'b1;
            rx_s2      <= 1'b1;
            rx_busy    <= 1'b0;
            rx_baud    <= '0;
            rx_bit     <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_s1      <= rx_i;
            rx_s2      <= rx_s1;
            rx_valid_o <= 1'b0;
            if (!rx_busy) begin
                if (!rx_s2) begin
                    // Half a bit ahead so ticks land mid-bit
                    rx_busy <= 1'b1;
                    rx_bit  <= '0;
                    rx_baud <= UART_CNT_W'(UART_CLKS_PER_BIT / 2);
                end
            end else if (rx_tick) begin
                rx_baud <= '0;
                rx_bit  <= rx_bit + 4'd1;
                if (rx_bit == 4'd0 && rx_s2) begin
                    rx_busy <= 1'b0;   // glitch, not a start bit
                end else if (rx_bit == 4'd9) begin
                    rx_busy    <= 1'b0;
                    rx_valid_o <= rx_s2;
                end
            end else begin
                rx_baud <= rx_baud + 1'b1;
            end
        end
    end

    // LSB first
    always_ff @(posedge clk) begin
        if (rx_busy && rx_tick && rx_bit != 4'd0 && rx_bit != 4'd9) begin
            rx_shift <= {rx_s2, rx_shift[7:1]};
        end
    end

    assign rx_data_o = rx_shift;

endmodule

// File: rtl/code_queue.sv
// Byte queue with a pop-on-request front end
// Holds the last popped code for software to read
`timescale 1ns/10ps

module code_queue #(
    parameter int AW = 3
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              push_i,
    input  periph_pkg::byte_t push_data_i,
    input  logic              pop_i,
    output logic              not_empty_o,
    output periph_pkg::byte_t code_o
);
    import periph_pkg::*;

    logic  empty;
    logic  full;
    logic  pop_q;
    byte_t fifo_data;

    // Pushes to a full queue are lost
    sync_fifo #(.AW(AW)) u_fifo (
        .clk       (clk),
        .reset_i   (reset_i),
        .wr_i      (push_i && !full),
        .wr_data_i (push_data_i),
        .rd_i      (pop_q),
        .rd_data_o (fifo_data),
        .empty_o   (empty),
        .full_o    (full)
    );

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pop_q <= 1'b0;
        end else begin
            pop_q <= pop_i && !empty;
        end
    end

    // Head of queue captured as the FIFO advances
    always_ff @(posedge clk) begin
        if (pop_q) begin
            code_o <= fifo_data;
        end
    end

    assign not_empty_o = !empty;

endmodule

// File: rtl/sync_fifo.sv
// Single-clock byte FIFO
// Depth of 2**AW entries, pointers carry an extra wrap bit
`timescale 1ns/10ps

module sync_fifo #(
    parameter int AW = 3
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              wr_i,
    input  periph_pkg::byte_t wr_data_i,
    input  logic              rd_i,
    output periph_pkg::byte_t rd_data_o,
    output logic              empty_o,
    output logic              full_o
);
    import periph_pkg::*;

    byte_t       mem [2**AW];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem[wr_ptr[AW-1:0]] <= wr_data_i;
        end
    end

    assign rd_data_o = mem[rd_ptr[AW-1:0]];

    // Same index, wrap bits tell full from empty
    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

endmodule

// File: rtl/periph_pkg.sv
// Peripheral register block shared definitions
// Bus widths, page map, register offsets, queue depths and UART timing
package periph_pkg;

    // APB bus, peripheral region prefix decoded upstream
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    typedef logic [7:0]        byte_t;
    typedef logic [DATA_W-1:0] word_t;

    // Page numbers, paddr[15:12]
    localparam logic [3:0] PAGE_DISPLAY = 4'd1;
    localparam logic [3:0] PAGE_UART    = 4'd2;
    localparam logic [3:0] PAGE_USB     = 4'd4;
    localparam logic [3:0] PAGE_KBD     = 4'd5;
    localparam logic [3:0] PAGE_SD      = 4'd6;
    localparam logic [3:0] PAGE_FLASH   = 4'd7;

    // Register offsets within a page, paddr[11:0]
    // UART   0 data, 4 status/pop
    // USB    0 valid, 4 MSW, 8 LSW
    // KBD    0 status/pop, 4 code
    // SD/FL  0 pins
    localparam logic [11:0] OFS_0 = 12'd0;
    localparam logic [11:0] OFS_4 = 12'd4;
    localparam logic [11:0] OFS_8 = 12'd8;

    // Serial bit timing
    localparam int UART_CLKS_PER_BIT = 8;
    localparam int UART_CNT_W        = $clog2(UART_CLKS_PER_BIT);

    // Queue depths as log2 of entries
    localparam int UART_Q_AW = 4;
    localparam int KBD_Q_AW  = 3;

endpackage
